/* Makefile */
# Verilator build and run of the reorder buffer testbench
TOP = tb_rob_unit
OBJ = obj_dir

.PHONY: build run clean

build:
	verilator --binary --timing --assert -Wno-fatal -f rob_unit.f \
		--top-module $(TOP) -Mdir $(OBJ)

# verdict comes from the log, not the simulator exit code
run: build
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf $(OBJ) sim.log

/* rob_unit.f */
src/rob_pkg.sv
src/rob_ctrl_if.sv
src/rob_fifo.sv
src/rob_status.sv
src/rob_commit_fsm.sv
src/rob_flush_timer.sv
src/rob_unit.sv
tests/tb_rob_unit.sv

/* src/rob_commit_fsm.sv */
`timescale 1ns/1ps
// commit sequencing, retires the head and handles mispredict flush
// gates dispatch while the front end recovers
module rob_commit_fsm (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_commit_ready,
    input  logic     i_timer_busy,
    output logic     o_timer_start,
    output logic     o_commit_valid,
    output logic     o_disp_enable,
    output logic     o_flush,
    rob_ctrl_if.ctrl ctrl
);
    import rob_pkg::*;

    commit_state_t state_q;
    commit_state_t state_d;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= RUN;
        end else begin
            state_q <= state_d;
        end
    end

    // head offered only when present and completed
    assign o_commit_valid = (state_q == RUN) && ctrl.head_valid && ctrl.head_done;
    assign ctrl.pop       = o_commit_valid && i_commit_ready;

    // timer starts at the mispredict pop, covering FLUSH and RECOVER
    assign o_timer_start = ctrl.pop && ctrl.head_mispredict;

    assign o_flush       = (state_q == FLUSH);
    assign ctrl.flush    = o_flush;
    assign o_disp_enable = (state_q == RUN);

    always_comb begin
        state_d = state_q;
        case (state_q)
            RUN: begin
                if (ctrl.pop && ctrl.head_mispredict) begin
                    state_d = FLUSH;
                end
            end
            // single flush cycle
            FLUSH:   state_d = RECOVER;
            RECOVER: begin
                if (!i_timer_busy) begin
                    state_d = RUN;
                end
            end
            default: state_d = RUN;
        endcase
    end

    // flush is a one-cycle pulse
    a_flush_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_flush |=> !o_flush);

    // stalled commit keeps offering the same head
    a_commit_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_commit_valid && !i_commit_ready |=> o_commit_valid && $stable(ctrl.head_tag));

endmodule

/* src/rob_ctrl_if.sv */
`timescale 1ns/1ps
// head status and pop/flush control between the commit FSM,
// the entry queue and the completion table
interface rob_ctrl_if;
    import rob_pkg::*;

    // head slot as seen by commit
    logic     head_valid;
    rob_tag_t head_tag;
    logic     head_done;
    logic     head_mispredict;

    // commit decisions
    logic     pop;
    logic     flush;

    // commit FSM side
    modport ctrl (
        output pop,
        output flush,
        input  head_valid,
        input  head_tag,
        input  head_done,
        input  head_mispredict
    );

    // queue owns the pointers
    modport queue (
        output head_valid,
        output head_tag,
        input  pop,
        input  flush
    );

    // completion table looks up the head slot
    modport track (
        output head_done,
        output head_mispredict,
        input  head_tag,
        input  flush
    );

endinterface

/* src/rob_fifo.sv */
`timescale 1ns/1ps
// circular in-order queue of reorder buffer entries
// tail index is the allocation tag, head feeds commit
module rob_fifo (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_push,
    input  rob_pkg::rob_entry_t i_entry,
    output logic                o_full,
    output rob_pkg::rob_tag_t   o_tail_tag,
    output rob_pkg::rob_entry_t o_head_entry,
    rob_ctrl_if.queue           ctrl
);
    import rob_pkg::*;

    // entry storage, payload only
    rob_entry_t     mem [ROB_DEPTH];

    // pointers carry one wrap bit above the index
    logic [TAG_W:0] head_q;
    logic [TAG_W:0] tail_q;
    logic [TAG_W:0] used;
    logic           empty;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            head_q <= '0;
            tail_q <= '0;
        end else if (ctrl.flush) begin
            // younger entries are dropped, tags restart at 0
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (i_push) begin
                tail_q <= tail_q + 1'b1;
            end
            if (ctrl.pop) begin
                head_q <= head_q + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem[tail_q[TAG_W-1:0]] <= i_entry;
        end
    end

    // occupancy from the pointer distance
    assign used  = tail_q - head_q;
    assign empty = (tail_q == head_q);

    assign o_full       = (used == (TAG_W + 1)'(ROB_DEPTH));
    assign o_tail_tag   = tail_q[TAG_W-1:0];
    assign o_head_entry = mem[head_q[TAG_W-1:0]];

    assign ctrl.head_valid = !empty;
    assign ctrl.head_tag   = head_q[TAG_W-1:0];

    // dispatch side must respect full
    a_push_not_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_push |-> !o_full);

    // commit only pops a present head
    a_pop_not_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        ctrl.pop |-> !empty);

endmodule

/* src/rob_flush_timer.sv */
`timescale 1ns/1ps
// recovery stall counter, loaded at the mispredict pop
// busy until the front end has had time to refetch
module rob_flush_timer (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_start,
    output logic o_busy
);
    import rob_pkg::*;

    // wide enough for the full recovery count
    logic [$clog2(RECOVER_CYCLES + 1)-1:0] cnt_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt_q <= '0;
        end else if (i_start) begin
            cnt_q <= $bits(cnt_q)'(RECOVER_CYCLES);
        end else if (cnt_q != '0) begin
            // one step per edge
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign o_busy = (cnt_q != '0);

endmodule

/* src/rob_pkg.sv */
// shared sizes and types of the reorder buffer
// imported by every block of the rob_unit design
package rob_pkg;

    // number of entries
    localparam int ROB_DEPTH = 8;
    // a tag is the slot index
    localparam int TAG_W = $clog2(ROB_DEPTH);

    // result width of the register file
    localparam int XLEN = 32;

    // cycles spent in RECOVER after the flush pulse
    localparam int RECOVER_CYCLES = 4;

    typedef logic [TAG_W-1:0] rob_tag_t;

    // what dispatch leaves in the queue
    typedef struct packed {
        logic [4:0] rd;
        logic       branch;
    } rob_entry_t;

    // commit sequencing
    typedef enum logic [1:0] {
        RUN,
        FLUSH,
        RECOVER
    } commit_state_t;

endpackage

/* src/rob_status.sv */
`timescale 1ns/1ps
// per-tag completion table written by the CDB
// reports done, value and mispredict of the head slot
module rob_status (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_alloc,
    input  rob_pkg::rob_tag_t        i_alloc_tag,
    input  logic                     i_cdb_valid,
    input  rob_pkg::rob_tag_t        i_cdb_tag,
    input  logic [rob_pkg::XLEN-1:0] i_cdb_value,
    input  logic                     i_cdb_mispredict,
    output logic [rob_pkg::XLEN-1:0] o_head_value,
    rob_ctrl_if.track                track
);
    import rob_pkg::*;

    // done bits are control, the rest is payload
    logic [ROB_DEPTH-1:0] done_q;
    logic [XLEN-1:0]      value_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] mis_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            done_q <= '0;
        end else if (track.flush) begin
            // in-flight results of flushed entries are lost
            done_q <= '0;
        end else begin
            // fresh slot starts not done
            if (i_alloc) begin
                done_q[i_alloc_tag] <= 1'b0;
            end
            if (i_cdb_valid) begin
                done_q[i_cdb_tag] <= 1'b1;
            end
        end
    end

    // result capture at the reported tag
    always_ff @(posedge i_clk) begin
        if (i_cdb_valid) begin
            value_q[i_cdb_tag] <= i_cdb_value;
            mis_q[i_cdb_tag]   <= i_cdb_mispredict;
        end
    end

    // head lookup, visible the cycle after the CDB edge
    assign track.head_done       = done_q[track.head_tag];
    assign track.head_mispredict = mis_q[track.head_tag];
    assign o_head_value          = value_q[track.head_tag];

    // each tag completes once per allocation
    a_cdb_single_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_cdb_valid |-> !done_q[i_cdb_tag]);

endmodule

/* src/rob_unit.sv */
`timescale 1ns/1ps
// reorder buffer top: dispatch allocation, CDB completion and in-order commit
// front end watches o_flush and refetches while dispatch is held off
module rob_unit (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    // dispatch
    input  logic                     i_disp_valid,
    input  logic [4:0]               i_disp_rd,
    input  logic                     i_disp_branch,
    output logic                     o_disp_ready,
    output rob_pkg::rob_tag_t        o_disp_tag,
    // CDB strobe
    input  logic                     i_cdb_valid,
    input  rob_pkg::rob_tag_t        i_cdb_tag,
    input  logic [rob_pkg::XLEN-1:0] i_cdb_value,
    input  logic                     i_cdb_mispredict,
    // commit to the register file
    output logic                     o_commit_valid,
    output rob_pkg::rob_tag_t        o_commit_tag,
    output logic [4:0]               o_commit_rd,
    output logic [rob_pkg::XLEN-1:0] o_commit_value,
    input  logic                     i_commit_ready,
    // front end redirect
    output logic                     o_flush
);
    import rob_pkg::*;

    rob_entry_t disp_entry;
    rob_entry_t head_entry;
    logic       disp_push;
    logic       disp_enable;
    logic       queue_full;
    logic       timer_start;
    logic       timer_busy;

    rob_ctrl_if ctrl_if ();

    // accept only in RUN with a free slot
    assign o_disp_ready = disp_enable && !queue_full;
    assign disp_push    = i_disp_valid && o_disp_ready;

    assign disp_entry.rd     = i_disp_rd;
    assign disp_entry.branch = i_disp_branch;

    rob_fifo u_rob_fifo (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_push       (disp_push),
        .i_entry      (disp_entry),
        .o_full       (queue_full),
        .o_tail_tag   (o_disp_tag),
        .o_head_entry (head_entry),
        .ctrl         (ctrl_if.queue)
    );

    // allocation tag is the tail slot being pushed
    rob_status u_rob_status (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_alloc          (disp_push),
        .i_alloc_tag      (o_disp_tag),
        .i_cdb_valid      (i_cdb_valid),
        .i_cdb_tag        (i_cdb_tag),
        .i_cdb_value      (i_cdb_value),
        .i_cdb_mispredict (i_cdb_mispredict),
        .o_head_value     (o_commit_value),
        .track            (ctrl_if.track)
    );

    rob_commit_fsm u_rob_commit_fsm (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_commit_ready (i_commit_ready),
        .i_timer_busy   (timer_busy),
        .o_timer_start  (timer_start),
        .o_commit_valid (o_commit_valid),
        .o_disp_enable  (disp_enable),
        .o_flush        (o_flush),
        .ctrl           (ctrl_if.ctrl)
    );

    rob_flush_timer u_rob_flush_timer (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (timer_start),
        .o_busy  (timer_busy)
    );

    // commit fields straight from the head slot
    assign o_commit_tag = ctrl_if.head_tag;
    assign o_commit_rd  = head_entry.rd;

    // only branches may report a mispredict
    a_mispredict_is_branch: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_commit_valid && ctrl_if.head_mispredict |-> head_entry.branch);

endmodule

/* tests/tb_rob_unit.sv */
`timescale 1ns/1ps
// table-driven testbench for rob_unit with a program-order scoreboard
// one table step per clock, inputs driven after the rising edge, checks at the falling edge
module tb_rob_unit;
    import rob_pkg::*;

    localparam int NSTEPS     = 42;
    localparam int CLK_PERIOD = 100;
    // generous cycle budget per step for the watchdog
    localparam int STEP_BOUND = 4;

    // nibbles: op, arg, flag, expected o_disp_ready (F = unchecked)
    // op 0 idle, 1 dispatch rd/branch, 2 CDB tag/mispredict, 3 commit ready level
    localparam logic [15:0] STEPS [NSTEPS] = '{
        16'h3_0_0_1,
        16'h1_1_0_F, 16'h1_2_0_F, 16'h1_3_0_F, 16'h1_4_0_F,
        16'h1_5_0_F, 16'h1_6_0_F, 16'h1_7_0_F, 16'h1_8_0_F,
        16'h0_0_0_0,
        // scrambled completion, head 0 last
        16'h3_1_0_F, 16'h2_2_0_F, 16'h2_1_0_F, 16'h0_0_0_F, 16'h2_0_0_F, 16'h0_0_0_F,
        16'h1_9_0_1,
        // commit stalled on tag 2
        16'h3_0_0_F, 16'h2_3_0_F, 16'h0_0_0_F, 16'h0_0_0_F, 16'h3_1_0_F,
        16'h2_5_0_F, 16'h2_4_0_F, 16'h2_7_0_F, 16'h2_6_0_F,
        // branch at tag 1 mispredicts, tags 2 and 3 are younger
        16'h1_A_1_F, 16'h1_B_0_F, 16'h1_C_0_F,
        16'h2_2_0_F, 16'h2_0_0_F, 16'h2_1_1_F, 16'h2_3_0_F,
        16'h0_0_0_0, 16'h0_0_0_0, 16'h0_0_0_0, 16'h0_0_0_0, 16'h0_0_0_0,
        16'h1_D_0_1, 16'h2_0_0_F, 16'h0_0_0_F, 16'h0_0_0_F
    };

    typedef struct packed {
        rob_tag_t   tag;
        logic [4:0] rd;
    } order_t;

    logic            i_clk, i_rst_n;
    logic            disp_valid, disp_branch, disp_ready;
    logic [4:0]      disp_rd, commit_rd, hold_rd;
    rob_tag_t        disp_tag, cdb_tag, commit_tag, hold_tag, m_tail;
    logic            cdb_valid, cdb_mispredict, commit_valid, commit_ready, flush, held;
    logic [XLEN-1:0] cdb_value, commit_value, hold_value, lcg_state;

    // program-order model
    order_t               order_q [$];
    logic [ROB_DEPTH-1:0] m_done, m_mis;
    logic [XLEN-1:0]      m_val [ROB_DEPTH];
    int                   rec, errors, checks;

    rob_unit u_rob_unit (
        .i_clk (i_clk), .i_rst_n (i_rst_n),
        .i_disp_valid (disp_valid), .i_disp_rd (disp_rd), .i_disp_branch (disp_branch),
        .o_disp_ready (disp_ready), .o_disp_tag (disp_tag),
        .i_cdb_valid (cdb_valid), .i_cdb_tag (cdb_tag), .i_cdb_value (cdb_value),
        .i_cdb_mispredict (cdb_mispredict),
        .o_commit_valid (commit_valid), .o_commit_tag (commit_tag), .o_commit_rd (commit_rd),
        .o_commit_value (commit_value), .i_commit_ready (commit_ready), .o_flush (flush)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic drive_step(input logic [15:0] code);
        disp_valid = 1'b0;
        cdb_valid  = 1'b0;
        case (code[15:12])
            4'd1: begin
                disp_valid  = 1'b1;
                disp_rd     = {1'b0, code[11:8]};
                disp_branch = code[4];
            end
            4'd2: begin
                lcg_state      = lcg_next(lcg_state);
                cdb_valid      = 1'b1;
                cdb_tag        = code[10:8];
                cdb_mispredict = code[4];
                cdb_value      = lcg_state;
            end
            4'd3: commit_ready = code[8];
            default: ;
        endcase
    endtask

    task automatic score_step(input logic [15:0] code);
        logic exp_ready, exp_cv, exp_flush;
        exp_ready = (rec == 0) && (order_q.size() < ROB_DEPTH);
        exp_cv    = (rec == 0) && (order_q.size() > 0) && m_done[order_q[0].tag];
        // FLUSH cycle is the first of the stall window
        exp_flush = (rec == RECOVER_CYCLES + 1);
        check("o_disp_ready", 32'(disp_ready), 32'(exp_ready));
        if (code[3:0] != 4'hF) check("o_disp_ready", 32'(disp_ready), 32'(code[0]));
        check("o_commit_valid", 32'(commit_valid), 32'(exp_cv));
        check("o_flush", 32'(flush), 32'(exp_flush));
        if (exp_ready) check("o_disp_tag", 32'(disp_tag), 32'(m_tail));
        if (exp_cv) begin
            check("o_commit_tag", 32'(commit_tag), 32'(order_q[0].tag));
            check("o_commit_rd", 32'(commit_rd), 32'(order_q[0].rd));
            check("o_commit_value", commit_value, m_val[order_q[0].tag]);
        end
        // stalled commit must not move
        if (held) begin
            check("o_commit_tag", 32'(commit_tag), 32'(hold_tag));
            check("o_commit_rd", 32'(commit_rd), 32'(hold_rd));
            check("o_commit_value", commit_value, hold_value);
        end
        // fields offered when the stall begins
        if (exp_cv && !commit_ready && !held) begin
            hold_tag   = order_q[0].tag;
            hold_rd    = order_q[0].rd;
            hold_value = m_val[order_q[0].tag];
        end
        held = exp_cv && !commit_ready;
        // model the coming edge
        if (rec > 0) begin
            if (rec == RECOVER_CYCLES + 1) begin
                order_q.delete();
                m_done = '0;
                m_tail = '0;
            end
            rec--;
        end else begin
            if (exp_cv && commit_ready) begin
                if (m_mis[order_q[0].tag]) rec = RECOVER_CYCLES + 1;
                void'(order_q.pop_front());
            end
            if (disp_valid && exp_ready) begin
                order_q.push_back('{tag: m_tail, rd: disp_rd});
                m_done[m_tail] = 1'b0;
                m_tail         = m_tail + 3'd1;
            end
            if (cdb_valid) begin
                m_done[cdb_tag] = 1'b1;
                m_mis[cdb_tag]  = cdb_mispredict;
                m_val[cdb_tag]  = cdb_value;
            end
        end
    endtask

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    initial begin
        #((10 + NSTEPS) * STEP_BOUND * CLK_PERIOD);
        $display("watchdog expired before the step table was done");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        {i_rst_n, disp_valid, disp_branch, cdb_valid, cdb_mispredict, commit_ready} = '0;
        {disp_rd, cdb_tag, cdb_value, m_tail, m_done, m_mis} = '0;
        {held, hold_tag, hold_rd, hold_value} = '0;
        {rec, errors, checks} = '0;
        lcg_state = 32'h48f5;
        repeat (10) @(posedge i_clk);
        #1 i_rst_n = 1'b1;
        for (int i = 0; i < NSTEPS; i++) begin
            @(posedge i_clk);
            #1 drive_step(STEPS[i]);
            @(negedge i_clk);
            score_step(STEPS[i]);
        end
        if (order_q.size() != 0) begin
            errors++;
            $display("%0d dispatched entries were never committed", order_q.size());
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
